// File: hdl/lc4_isa_pkg.sv
`default_nettype none

package lc4_isa_pkg;

   typedef logic [15:0] word_t;
   typedef logic [2:0]  reg_idx_t;

   // only the opcodes the core still executes
   typedef enum logic [3:0] {
      OP_ARITH   = 4'b0001,
      OP_LOGIC   = 4'b0101,
      OP_CONST   = 4'b1001,
      OP_HICONST = 4'b1101
   } opcode_e;

   // bit 2 of the sub field doubles as the immediate flag
   typedef enum logic [2:0] {
      ARITH_ADD = 3'd0,
      ARITH_MUL = 3'd1,
      ARITH_SUB = 3'd2,
      ARITH_DIV = 3'd3
   } arith_sub_e;

   typedef enum logic [2:0] {
      LOGIC_AND = 3'd0,
      LOGIC_NOT = 3'd1,
      LOGIC_OR  = 3'd2,
      LOGIC_XOR = 3'd3
   } logic_sub_e;

   typedef struct packed {
      opcode_e    opcode;
      reg_idx_t   rd;
      reg_idx_t   rs;
      logic [2:0] sub;
      reg_idx_t   rt;
   } insn_r_t;

   typedef struct packed {
      opcode_e    opcode;
      reg_idx_t   rd;
      reg_idx_t   rs;
      logic       imm_flag;
      logic [4:0] imm5;
   } insn_i_t;

   typedef struct packed {
      opcode_e    opcode;
      reg_idx_t   rd;
      logic [8:0] imm9;   // HICONST uses the low 8 bits
   } insn_c_t;

   typedef union packed {
      insn_r_t r;
      insn_i_t i;
      insn_c_t c;
   } insn_u;

endpackage

`default_nettype wire

// File: hdl/lc4_pipe_pkg.sv
`default_nettype none

package lc4_pipe_pkg;

   localparam lc4_isa_pkg::word_t RESET_PC = 16'h8200;

   typedef enum logic [1:0] {
      STALL_NONE  = 2'd0,
      STALL_SPLIT = 2'd1,   // held back behind its partner
      STALL_EMPTY = 2'd2    // reset bubble or zero word
   } stall_e;

   // one issued slot on its way into execute
   typedef struct packed {
      lc4_isa_pkg::word_t    pc;
      lc4_isa_pkg::word_t    insn;
      lc4_isa_pkg::reg_idx_t rs_sel;
      lc4_isa_pkg::reg_idx_t rt_sel;
      lc4_isa_pkg::word_t    rs_val;
      lc4_isa_pkg::word_t    rt_val;
      lc4_isa_pkg::reg_idx_t wsel;
      logic                  we;
      stall_e                stall;
   } lane_t;

   localparam lane_t LANE_IDLE = '{stall: STALL_EMPTY, default: '0};

   // lane B beats lane A, and both beat the stored value
   function automatic lc4_isa_pkg::word_t bypass(
      input lc4_isa_pkg::reg_idx_t idx,
      input lc4_isa_pkg::word_t    stored,
      input logic                  we_a,
      input lc4_isa_pkg::reg_idx_t wsel_a,
      input lc4_isa_pkg::word_t    data_a,
      input logic                  we_b,
      input lc4_isa_pkg::reg_idx_t wsel_b,
      input lc4_isa_pkg::word_t    data_b
   );
      if (we_b && wsel_b == idx)
         return data_b;
      if (we_a && wsel_a == idx)
         return data_a;
      return stored;
   endfunction

endpackage

`default_nettype wire

// File: hdl/lane_result_if.sv
`default_nettype none

// one lane's writeback result, registered at the end of execute
interface lane_result_if;

   logic                  we;
   lc4_isa_pkg::reg_idx_t wsel;
   lc4_isa_pkg::word_t    data;
   lc4_isa_pkg::word_t    pc;
   lc4_isa_pkg::word_t    insn;
   lc4_pipe_pkg::stall_e  stall;

   modport src  (output we, wsel, data, pc, insn, stall);
   modport sink (input  we, wsel, data, pc, insn, stall);

endinterface

`default_nettype wire

// File: hdl/fetch_unit.sv
`default_nettype none

module fetch_unit (
   input  wire                         gwe,
   input  wire                         i_rst_n,
   input  wire lc4_isa_pkg::word_t     i_imem_insn_a,   // word at pc
   input  wire lc4_isa_pkg::word_t     i_imem_insn_b,   // word at pc + 1
   input  wire                         i_split,
   output lc4_isa_pkg::word_t          o_imem_addr,
   output lc4_isa_pkg::word_t          o_pc_a,
   output lc4_isa_pkg::word_t          o_pc_b,
   output lc4_isa_pkg::word_t          o_insn_a,
   output lc4_isa_pkg::word_t          o_insn_b,
   output lc4_pipe_pkg::stall_e        o_stall_a,
   output lc4_pipe_pkg::stall_e        o_stall_b
);

   lc4_isa_pkg::word_t pc;
   lc4_isa_pkg::word_t nxt_pc_a;
   lc4_isa_pkg::word_t nxt_pc_b;
   lc4_isa_pkg::word_t nxt_insn_a;
   lc4_isa_pkg::word_t nxt_insn_b;

   assign o_imem_addr = pc;

   // on a split the held-back B moves up to A and only one new word enters
   assign nxt_pc_a   = i_split ? o_pc_b : pc;
   assign nxt_pc_b   = i_split ? pc : pc + 16'd1;
   assign nxt_insn_a = i_split ? o_insn_b : i_imem_insn_a;
   assign nxt_insn_b = i_split ? i_imem_insn_a : i_imem_insn_b;

   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         pc        <= lc4_pipe_pkg::RESET_PC;
         o_pc_a    <= '0;
         o_pc_b    <= '0;
         o_insn_a  <= '0;
         o_insn_b  <= '0;
         o_stall_a <= lc4_pipe_pkg::STALL_EMPTY;
         o_stall_b <= lc4_pipe_pkg::STALL_EMPTY;
      end else begin
         pc       <= i_split ? pc + 16'd1 : pc + 16'd2;
         o_pc_a   <= nxt_pc_a;
         o_pc_b   <= nxt_pc_b;
         o_insn_a <= nxt_insn_a;
         o_insn_b <= nxt_insn_b;
         // a zero word travels as a bubble
         o_stall_a <= (nxt_insn_a == '0) ? lc4_pipe_pkg::STALL_EMPTY : lc4_pipe_pkg::STALL_NONE;
         o_stall_b <= (nxt_insn_b == '0) ? lc4_pipe_pkg::STALL_EMPTY : lc4_pipe_pkg::STALL_NONE;
      end
   end

endmodule

`default_nettype wire

// File: hdl/issue_unit.sv
`default_nettype none

module issue_unit (
   input  wire                         gwe,
   input  wire                         i_rst_n,
   input  wire lc4_isa_pkg::word_t     i_pc_a,
   input  wire lc4_isa_pkg::word_t     i_pc_b,
   input  wire lc4_isa_pkg::word_t     i_insn_a,
   input  wire lc4_isa_pkg::word_t     i_insn_b,
   input  wire lc4_pipe_pkg::stall_e   i_stall_a,
   input  wire lc4_pipe_pkg::stall_e   i_stall_b,
   output lc4_isa_pkg::reg_idx_t       o_rs_a,
   output lc4_isa_pkg::reg_idx_t       o_rt_a,
   output lc4_isa_pkg::reg_idx_t       o_rs_b,
   output lc4_isa_pkg::reg_idx_t       o_rt_b,
   input  wire lc4_isa_pkg::word_t     i_rs_data_a,
   input  wire lc4_isa_pkg::word_t     i_rt_data_a,
   input  wire lc4_isa_pkg::word_t     i_rs_data_b,
   input  wire lc4_isa_pkg::word_t     i_rt_data_b,
   output logic                        o_split,
   output lc4_pipe_pkg::lane_t         o_lane_a,
   output lc4_pipe_pkg::lane_t         o_lane_b
);

   lc4_isa_pkg::reg_idx_t wsel_a;
   lc4_isa_pkg::reg_idx_t wsel_b;
   logic                  we_a;
   logic                  we_b;
   lc4_pipe_pkg::lane_t   lane_a;
   lc4_pipe_pkg::lane_t   lane_b;

   // read ports, write target and write enable of one slot
   function automatic void decode(
      input  lc4_isa_pkg::word_t    w,
      output lc4_isa_pkg::reg_idx_t rs,
      output lc4_isa_pkg::reg_idx_t rt,
      output lc4_isa_pkg::reg_idx_t wsel,
      output logic                  we
   );
      lc4_isa_pkg::insn_u u;
      u    = w;
      rs   = (u.r.opcode == lc4_isa_pkg::OP_HICONST) ? u.c.rd : u.r.rs;  // HICONST merges into rd
      rt   = u.r.rt;
      wsel = u.r.rd;
      case (u.r.opcode)
         lc4_isa_pkg::OP_ARITH:
            we = u.i.imm_flag || u.r.sub == lc4_isa_pkg::ARITH_ADD ||
                 u.r.sub == lc4_isa_pkg::ARITH_SUB;
         lc4_isa_pkg::OP_LOGIC, lc4_isa_pkg::OP_CONST, lc4_isa_pkg::OP_HICONST:
            we = 1'b1;
         default:
            we = 1'b0;
      endcase
   endfunction

   // true when the slot's read set contains register r
   function automatic logic reads(input lc4_isa_pkg::word_t w, input lc4_isa_pkg::reg_idx_t r);
      lc4_isa_pkg::insn_u u;
      u = w;
      case (u.r.opcode)
         lc4_isa_pkg::OP_ARITH:
            return u.r.rs == r || (!u.i.imm_flag && u.r.rt == r);
         lc4_isa_pkg::OP_LOGIC:
            return u.r.rs == r ||
                   (!u.i.imm_flag && u.r.sub != lc4_isa_pkg::LOGIC_NOT && u.r.rt == r);
         lc4_isa_pkg::OP_HICONST:
            return u.c.rd == r;
         default:
            return 1'b0;   // CONST and no-ops read nothing
      endcase
   endfunction

   always_comb begin
      decode(i_insn_a, o_rs_a, o_rt_a, wsel_a, we_a);
      decode(i_insn_b, o_rs_b, o_rt_b, wsel_b, we_b);
      o_split = we_a && reads(i_insn_b, wsel_a);   // B must wait for A's result
   end

   always_comb begin
      lane_a = '{pc: i_pc_a, insn: i_insn_a, rs_sel: o_rs_a, rt_sel: o_rt_a,
                 rs_val: i_rs_data_a, rt_val: i_rt_data_a, wsel: wsel_a, we: we_a,
                 stall: i_stall_a};
      lane_b = '{pc: i_pc_b, insn: i_insn_b, rs_sel: o_rs_b, rt_sel: o_rt_b,
                 rs_val: i_rs_data_b, rt_val: i_rt_data_b, wsel: wsel_b, we: we_b,
                 stall: i_stall_b};
      if (o_split) begin
         lane_b       = lc4_pipe_pkg::LANE_IDLE;
         lane_b.stall = lc4_pipe_pkg::STALL_SPLIT;   // reissued next cycle as slot A
      end
   end

   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         o_lane_a <= lc4_pipe_pkg::LANE_IDLE;
         o_lane_b <= lc4_pipe_pkg::LANE_IDLE;
      end else begin
         o_lane_a <= lane_a;
         o_lane_b <= lane_b;
      end
   end

endmodule

`default_nettype wire

// File: hdl/regfile_2w4r.sv
`default_nettype none

module regfile_2w4r (
   input  wire                         gwe,
   input  wire                         i_rst_n,
   input  wire lc4_isa_pkg::reg_idx_t  i_rs_a,
   input  wire lc4_isa_pkg::reg_idx_t  i_rt_a,
   input  wire lc4_isa_pkg::reg_idx_t  i_rs_b,
   input  wire lc4_isa_pkg::reg_idx_t  i_rt_b,
   output lc4_isa_pkg::word_t          o_rs_data_a,
   output lc4_isa_pkg::word_t          o_rt_data_a,
   output lc4_isa_pkg::word_t          o_rs_data_b,
   output lc4_isa_pkg::word_t          o_rt_data_b,
   lane_result_if.sink                 lane_a,
   lane_result_if.sink                 lane_b
);

   lc4_isa_pkg::word_t regs [8];

   // write-through, the value being written this cycle is read back directly
   function automatic lc4_isa_pkg::word_t rd_port(input lc4_isa_pkg::reg_idx_t idx);
      return lc4_pipe_pkg::bypass(idx, regs[idx], lane_a.we, lane_a.wsel, lane_a.data,
                                  lane_b.we, lane_b.wsel, lane_b.data);
   endfunction

   always_comb begin
      o_rs_data_a = rd_port(i_rs_a);
      o_rt_data_a = rd_port(i_rt_a);
      o_rs_data_b = rd_port(i_rs_b);
      o_rt_data_b = rd_port(i_rt_b);
   end

   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         regs <= '{default: '0};
      end else begin
         if (lane_a.we)
            regs[lane_a.wsel] <= lane_a.data;
         if (lane_b.we)
            regs[lane_b.wsel] <= lane_b.data;   // later slot wins on the same target
      end
   end

endmodule

`default_nettype wire

// File: hdl/lc4_alu_lite.sv
`default_nettype none

module lc4_alu_lite (
   input  wire lc4_isa_pkg::word_t i_insn,
   input  wire lc4_isa_pkg::word_t i_rs_val,
   input  wire lc4_isa_pkg::word_t i_rt_val,
   output lc4_isa_pkg::word_t      o_result,
   output logic                    o_we
);

   lc4_isa_pkg::insn_u u;
   lc4_isa_pkg::word_t sext5;

   assign u     = i_insn;
   assign sext5 = {{11{u.i.imm5[4]}}, u.i.imm5};

   always_comb begin
      o_result = '0;
      o_we     = 1'b1;
      case (u.r.opcode)
         lc4_isa_pkg::OP_ARITH: begin
            case (u.r.sub)
               lc4_isa_pkg::ARITH_ADD: o_result = i_rs_val + i_rt_val;
               lc4_isa_pkg::ARITH_SUB: o_result = i_rs_val - i_rt_val;
               lc4_isa_pkg::ARITH_MUL, lc4_isa_pkg::ARITH_DIV:
                  o_we = 1'b0;   // not kept, no-op
               default: o_result = i_rs_val + sext5;   // immediate flag set
            endcase
         end
         lc4_isa_pkg::OP_LOGIC: begin
            case (u.r.sub)
               lc4_isa_pkg::LOGIC_AND: o_result = i_rs_val & i_rt_val;
               lc4_isa_pkg::LOGIC_NOT: o_result = ~i_rs_val;
               lc4_isa_pkg::LOGIC_OR:  o_result = i_rs_val | i_rt_val;
               lc4_isa_pkg::LOGIC_XOR: o_result = i_rs_val ^ i_rt_val;
               default: o_result = i_rs_val & sext5;
            endcase
         end
         lc4_isa_pkg::OP_CONST:
            o_result = {{7{u.c.imm9[8]}}, u.c.imm9};
         lc4_isa_pkg::OP_HICONST:
            o_result = {u.c.imm9[7:0], i_rs_val[7:0]};   // rs carries the old rd here
         default:
            o_we = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

// File: hdl/execute_stage.sv
`default_nettype none

module execute_stage (
   input  wire                         gwe,
   input  wire                         i_rst_n,
   input  wire lc4_pipe_pkg::lane_t    i_lane_a,
   input  wire lc4_pipe_pkg::lane_t    i_lane_b,
   lane_result_if.src                  lane_a,
   lane_result_if.src                  lane_b
);

   lc4_isa_pkg::word_t rs_a;
   lc4_isa_pkg::word_t rt_a;
   lc4_isa_pkg::word_t rs_b;
   lc4_isa_pkg::word_t rt_b;
   lc4_isa_pkg::word_t res_a;
   lc4_isa_pkg::word_t res_b;
   logic               alu_we_a;
   logic               alu_we_b;

   // the pair ahead sits in writeback and was not yet visible at issue
   function automatic lc4_isa_pkg::word_t fwd(input lc4_isa_pkg::reg_idx_t idx,
                                              input lc4_isa_pkg::word_t stale);
      return lc4_pipe_pkg::bypass(idx, stale, lane_a.we, lane_a.wsel, lane_a.data,
                                  lane_b.we, lane_b.wsel, lane_b.data);
   endfunction

   always_comb begin
      rs_a = fwd(i_lane_a.rs_sel, i_lane_a.rs_val);
      rt_a = fwd(i_lane_a.rt_sel, i_lane_a.rt_val);
      rs_b = fwd(i_lane_b.rs_sel, i_lane_b.rs_val);
      rt_b = fwd(i_lane_b.rt_sel, i_lane_b.rt_val);
   end

   lc4_alu_lite alu_a (
      .i_insn   (i_lane_a.insn),
      .i_rs_val (rs_a),
      .i_rt_val (rt_a),
      .o_result (res_a),
      .o_we     (alu_we_a)
   );

   lc4_alu_lite alu_b (
      .i_insn   (i_lane_b.insn),
      .i_rs_val (rs_b),
      .i_rt_val (rt_b),
      .o_result (res_b),
      .o_we     (alu_we_b)
   );

   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         lane_a.we    <= 1'b0;
         lane_a.wsel  <= '0;
         lane_a.data  <= '0;
         lane_a.pc    <= '0;
         lane_a.insn  <= '0;
         lane_a.stall <= lc4_pipe_pkg::STALL_EMPTY;
         lane_b.we    <= 1'b0;
         lane_b.wsel  <= '0;
         lane_b.data  <= '0;
         lane_b.pc    <= '0;
         lane_b.insn  <= '0;
         lane_b.stall <= lc4_pipe_pkg::STALL_EMPTY;
      end else begin
         lane_a.we    <= i_lane_a.we & alu_we_a;
         lane_a.wsel  <= i_lane_a.wsel;
         lane_a.data  <= res_a;
         lane_a.pc    <= i_lane_a.pc;
         lane_a.insn  <= i_lane_a.insn;
         lane_a.stall <= i_lane_a.stall;
         lane_b.we    <= i_lane_b.we & alu_we_b;   // cleared split slot has we low
         lane_b.wsel  <= i_lane_b.wsel;
         lane_b.data  <= res_b;
         lane_b.pc    <= i_lane_b.pc;
         lane_b.insn  <= i_lane_b.insn;
         lane_b.stall <= i_lane_b.stall;
      end
   end

endmodule

`default_nettype wire

// File: hdl/lc4_superscalar_top.sv
`default_nettype none

module lc4_superscalar_top (
   input  wire                         gwe,
   input  wire                         i_rst_n,
   input  wire lc4_isa_pkg::word_t     i_imem_insn_a,
   input  wire lc4_isa_pkg::word_t     i_imem_insn_b,
   output lc4_isa_pkg::word_t          o_imem_addr,
   output lc4_isa_pkg::word_t          o_wb_pc_a,
   output lc4_isa_pkg::word_t          o_wb_insn_a,
   output logic                        o_wb_we_a,
   output lc4_isa_pkg::reg_idx_t       o_wb_wsel_a,
   output lc4_isa_pkg::word_t          o_wb_data_a,
   output lc4_pipe_pkg::stall_e        o_wb_stall_a,
   output lc4_isa_pkg::word_t          o_wb_pc_b,
   output lc4_isa_pkg::word_t          o_wb_insn_b,
   output logic                        o_wb_we_b,
   output lc4_isa_pkg::reg_idx_t       o_wb_wsel_b,
   output lc4_isa_pkg::word_t          o_wb_data_b,
   output lc4_pipe_pkg::stall_e        o_wb_stall_b
);

   lc4_isa_pkg::word_t    pc_a;
   lc4_isa_pkg::word_t    pc_b;
   lc4_isa_pkg::word_t    insn_a;
   lc4_isa_pkg::word_t    insn_b;
   lc4_pipe_pkg::stall_e  stall_a;
   lc4_pipe_pkg::stall_e  stall_b;
   logic                  split;
   lc4_isa_pkg::reg_idx_t rs_a;
   lc4_isa_pkg::reg_idx_t rt_a;
   lc4_isa_pkg::reg_idx_t rs_b;
   lc4_isa_pkg::reg_idx_t rt_b;
   lc4_isa_pkg::word_t    rs_data_a;
   lc4_isa_pkg::word_t    rt_data_a;
   lc4_isa_pkg::word_t    rs_data_b;
   lc4_isa_pkg::word_t    rt_data_b;
   lc4_pipe_pkg::lane_t   ex_lane_a;
   lc4_pipe_pkg::lane_t   ex_lane_b;

   lane_result_if lane_a ();
   lane_result_if lane_b ();

   fetch_unit fetch_unit_inst (
      .gwe           (gwe),
      .i_rst_n       (i_rst_n),
      .i_imem_insn_a (i_imem_insn_a),
      .i_imem_insn_b (i_imem_insn_b),
      .i_split       (split),
      .o_imem_addr   (o_imem_addr),
      .o_pc_a        (pc_a),
      .o_pc_b        (pc_b),
      .o_insn_a      (insn_a),
      .o_insn_b      (insn_b),
      .o_stall_a     (stall_a),
      .o_stall_b     (stall_b)
   );

   issue_unit issue_unit_inst (
      .gwe         (gwe),
      .i_rst_n     (i_rst_n),
      .i_pc_a      (pc_a),
      .i_pc_b      (pc_b),
      .i_insn_a    (insn_a),
      .i_insn_b    (insn_b),
      .i_stall_a   (stall_a),
      .i_stall_b   (stall_b),
      .o_rs_a      (rs_a),
      .o_rt_a      (rt_a),
      .o_rs_b      (rs_b),
      .o_rt_b      (rt_b),
      .i_rs_data_a (rs_data_a),
      .i_rt_data_a (rt_data_a),
      .i_rs_data_b (rs_data_b),
      .i_rt_data_b (rt_data_b),
      .o_split     (split),
      .o_lane_a    (ex_lane_a),
      .o_lane_b    (ex_lane_b)
   );

   regfile_2w4r regfile_inst (
      .gwe         (gwe),
      .i_rst_n     (i_rst_n),
      .i_rs_a      (rs_a),
      .i_rt_a      (rt_a),
      .i_rs_b      (rs_b),
      .i_rt_b      (rt_b),
      .o_rs_data_a (rs_data_a),
      .o_rt_data_a (rt_data_a),
      .o_rs_data_b (rs_data_b),
      .o_rt_data_b (rt_data_b),
      .lane_a      (lane_a),
      .lane_b      (lane_b)
   );

   execute_stage execute_stage_inst (
      .gwe      (gwe),
      .i_rst_n  (i_rst_n),
      .i_lane_a (ex_lane_a),
      .i_lane_b (ex_lane_b),
      .lane_a   (lane_a),
      .lane_b   (lane_b)
   );

   // trace ports show the writeback registers
   assign o_wb_pc_a    = lane_a.pc;
   assign o_wb_insn_a  = lane_a.insn;
   assign o_wb_we_a    = lane_a.we;
   assign o_wb_wsel_a  = lane_a.wsel;
   assign o_wb_data_a  = lane_a.data;
   assign o_wb_stall_a = lane_a.stall;
   assign o_wb_pc_b    = lane_b.pc;
   assign o_wb_insn_b  = lane_b.insn;
   assign o_wb_we_b    = lane_b.we;
   assign o_wb_wsel_b  = lane_b.wsel;
   assign o_wb_data_b  = lane_b.data;
   assign o_wb_stall_b = lane_b.stall;

endmodule

`default_nettype wire

// File: tests/tb_lc4_superscalar.sv
`default_nettype none

module tb_lc4_superscalar;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int          CLK_PERIOD  = 100;
   localparam int          DRIVE_DLY   = 5;    // input drive after the rising edge
   localparam int          RST_CYCLES  = 8;
   localparam int          PIPE_DEPTH  = 3;    // fetch, issue, execute
   localparam int          LIVE_CYC    = RST_CYCLES + PIPE_DEPTH;
   localparam int          MEM_WORDS   = 256;
   localparam int          N_RANDOM    = 96;
   localparam int          WDOG_MARGIN = 20;
   localparam logic [31:0] RAND_SEED   = 32'hb6e2d15c;

   logic                  gwe;
   logic                  rst_n;
   lc4_isa_pkg::word_t    imem_insn_a;
   lc4_isa_pkg::word_t    imem_insn_b;
   lc4_isa_pkg::word_t    imem_addr;
   lc4_isa_pkg::word_t    wb_pc    [2];
   lc4_isa_pkg::word_t    wb_insn  [2];
   logic                  wb_we    [2];
   lc4_isa_pkg::reg_idx_t wb_wsel  [2];
   lc4_isa_pkg::word_t    wb_data  [2];
   lc4_pipe_pkg::stall_e  wb_stall [2];

   // reference model state and its prediction for the slots now on the trace
   lc4_isa_pkg::word_t    mem        [MEM_WORDS];
   lc4_isa_pkg::word_t    model_regs [8];
   lc4_isa_pkg::word_t    model_pc = lc4_pipe_pkg::RESET_PC;
   lc4_isa_pkg::word_t    exp_pc    [2];
   lc4_isa_pkg::word_t    exp_insn  [2];
   logic                  exp_we    [2];
   lc4_isa_pkg::reg_idx_t exp_wsel  [2];
   lc4_isa_pkg::word_t    exp_data  [2];
   lc4_pipe_pkg::stall_e  exp_stall [2];

   int   cyc          = 0;
   int   prog_len     = 0;
   int   startup_errs = 0;
   int   trace_errs   = 0;
   int   data_errs    = 0;
   logic loaded       = 1'b0;

   lc4_superscalar_top lc4_superscalar_top_inst (
      .gwe           (gwe),
      .i_rst_n       (rst_n),
      .i_imem_insn_a (imem_insn_a),
      .i_imem_insn_b (imem_insn_b),
      .o_imem_addr   (imem_addr),
      .o_wb_pc_a     (wb_pc[0]),
      .o_wb_insn_a   (wb_insn[0]),
      .o_wb_we_a     (wb_we[0]),
      .o_wb_wsel_a   (wb_wsel[0]),
      .o_wb_data_a   (wb_data[0]),
      .o_wb_stall_a  (wb_stall[0]),
      .o_wb_pc_b     (wb_pc[1]),
      .o_wb_insn_b   (wb_insn[1]),
      .o_wb_we_b     (wb_we[1]),
      .o_wb_wsel_b   (wb_wsel[1]),
      .o_wb_data_b   (wb_data[1]),
      .o_wb_stall_b  (wb_stall[1])
   );

   function automatic lc4_isa_pkg::word_t enc_reg(input logic [3:0] op, input int rd,
                                                  input int rs, input int sub, input int rt);
      return {op, 3'(rd), 3'(rs), 3'(sub), 3'(rt)};
   endfunction

   function automatic lc4_isa_pkg::word_t enc_imm(input logic [3:0] op, input int rd,
                                                  input int rs, input int imm);
      return {op, 3'(rd), 3'(rs), 1'b1, 5'(imm)};
   endfunction

   function automatic lc4_isa_pkg::word_t enc_const(input logic [3:0] op, input int rd,
                                                    input int imm);
      return {op, 3'(rd), 9'(imm)};
   endfunction

   function automatic lc4_isa_pkg::word_t mem_word(input lc4_isa_pkg::word_t addr);
      lc4_isa_pkg::word_t off;
      off = addr - lc4_pipe_pkg::RESET_PC;
      if (off < 16'(MEM_WORDS))
         return mem[off[7:0]];
      return '0;   // outside the program window reads as a zero word
   endfunction

   function automatic logic writes_reg(input lc4_isa_pkg::word_t w);
      case (w[15:12])
         lc4_isa_pkg::OP_ARITH:
            return w[5] || w[5:3] == 3'd0 || w[5:3] == 3'd2;
         lc4_isa_pkg::OP_LOGIC, lc4_isa_pkg::OP_CONST, lc4_isa_pkg::OP_HICONST:
            return 1'b1;
         default:
            return 1'b0;
      endcase
   endfunction

   function automatic logic reads_reg(input lc4_isa_pkg::word_t w, input logic [2:0] r);
      case (w[15:12])
         lc4_isa_pkg::OP_ARITH:
            return w[8:6] == r || (!w[5] && w[2:0] == r);
         lc4_isa_pkg::OP_LOGIC:
            return w[8:6] == r || (!w[5] && w[5:3] != 3'd1 && w[2:0] == r);  // NOT reads rs only
         lc4_isa_pkg::OP_HICONST:
            return w[11:9] == r;
         default:
            return 1'b0;
      endcase
   endfunction

   // architectural result of a word that writes
   function automatic lc4_isa_pkg::word_t exec_word(input lc4_isa_pkg::word_t w);
      lc4_isa_pkg::word_t rs;
      lc4_isa_pkg::word_t rt;
      lc4_isa_pkg::word_t imm5;
      rs   = model_regs[w[8:6]];
      rt   = model_regs[w[2:0]];
      imm5 = {{11{w[4]}}, w[4:0]};
      case (w[15:12])
         lc4_isa_pkg::OP_ARITH: begin
            case (w[5:3])
               3'd0:    return rs + rt;
               3'd2:    return rs - rt;
               default: return rs + imm5;
            endcase
         end
         lc4_isa_pkg::OP_LOGIC: begin
            case (w[5:3])
               3'd0:    return rs & rt;
               3'd1:    return ~rs;
               3'd2:    return rs | rt;
               3'd3:    return rs ^ rt;
               default: return rs & imm5;
            endcase
         end
         lc4_isa_pkg::OP_CONST:
            return {{7{w[8]}}, w[8:0]};
         lc4_isa_pkg::OP_HICONST:
            return {w[7:0], model_regs[w[11:9]][7:0]};
         default:
            return '0;
      endcase
   endfunction

   task automatic predict_slot(input logic l, input lc4_isa_pkg::word_t w);
      exp_pc[l]    = model_pc;
      exp_insn[l]  = w;
      exp_stall[l] = (w == '0) ? lc4_pipe_pkg::STALL_EMPTY : lc4_pipe_pkg::STALL_NONE;
      exp_we[l]    = writes_reg(w);
      exp_wsel[l]  = w[11:9];
      if (exp_we[l]) begin
         exp_data[l]         = exec_word(w);
         model_regs[w[11:9]] = exp_data[l];
      end
      model_pc = model_pc + 16'd1;
   endtask

   task automatic predict_pair();
      lc4_isa_pkg::word_t wa;
      lc4_isa_pkg::word_t wb;
      wa = mem_word(model_pc);
      predict_slot(1'b0, wa);
      wb = mem_word(model_pc);
      if (writes_reg(wa) && reads_reg(wb, wa[11:9])) begin
         exp_stall[1] = lc4_pipe_pkg::STALL_SPLIT;   // B returns as the next A
         exp_we[1]    = 1'b0;
      end else begin
         predict_slot(1'b1, wb);
      end
   endtask

   task automatic put_word(input lc4_isa_pkg::word_t w);
      mem[prog_len[7:0]] = w;
      prog_len++;
   endtask

   task automatic load_program();
      lc4_isa_pkg::word_t w;
      // independent pairs, constants and immediates
      put_word(enc_const(lc4_isa_pkg::OP_CONST, 1, 5));
      put_word(enc_const(lc4_isa_pkg::OP_CONST, 2, -3));
      put_word(enc_reg(lc4_isa_pkg::OP_ARITH, 3, 1, 0, 2));   // operands from writeback
      put_word(enc_reg(lc4_isa_pkg::OP_ARITH, 4, 1, 2, 2));
      put_word(enc_const(lc4_isa_pkg::OP_HICONST, 1, 'hA5));
      put_word(enc_imm(lc4_isa_pkg::OP_ARITH, 5, 3, -4));
      put_word(enc_imm(lc4_isa_pkg::OP_LOGIC, 6, 4, 7));
      put_word(enc_reg(lc4_isa_pkg::OP_LOGIC, 7, 1, 3, 2));
      put_word(enc_reg(lc4_isa_pkg::OP_LOGIC, 0, 3, 1, 0));
      put_word(enc_reg(lc4_isa_pkg::OP_LOGIC, 5, 5, 2, 6));
      // dependent chains
      put_word(enc_imm(lc4_isa_pkg::OP_ARITH, 1, 1, 1));
      put_word(enc_reg(lc4_isa_pkg::OP_ARITH, 2, 1, 0, 1));
      put_word(enc_reg(lc4_isa_pkg::OP_LOGIC, 3, 2, 0, 1));
      put_word(enc_const(lc4_isa_pkg::OP_CONST, 4, 'h0FF));
      put_word(enc_const(lc4_isa_pkg::OP_CONST, 6, 'h034));
      put_word(enc_const(lc4_isa_pkg::OP_HICONST, 6, 'h7E));   // reads its own rd
      put_word(16'h0000);
      put_word(enc_reg(lc4_isa_pkg::OP_ARITH, 0, 6, 0, 4));
      // no-ops, bubbles and a shared target
      put_word(enc_reg(lc4_isa_pkg::OP_ARITH, 1, 2, 1, 3));   // MUL
      put_word(16'h6A45);
      put_word(16'h0000);
      put_word(16'h0000);
      put_word(enc_reg(lc4_isa_pkg::OP_ARITH, 2, 2, 3, 2));   // DIV
      put_word(enc_reg(lc4_isa_pkg::OP_LOGIC, 7, 1, 2, 2));
      put_word(enc_reg(lc4_isa_pkg::OP_ARITH, 7, 1, 0, 1));   // same pair, B's r7 must win
      put_word(enc_reg(lc4_isa_pkg::OP_ARITH, 7, 7, 2, 3));
      put_word(enc_reg(lc4_isa_pkg::OP_ARITH, 0, 7, 2, 7));
      put_word(enc_imm(lc4_isa_pkg::OP_LOGIC, 0, 0, -1));
      for (int i = 0; i < N_RANDOM; i++) begin
         w        = 16'($urandom);
         w[15:12] = ($urandom % 5 == 4) ? 4'h6 : {w[13:12], 2'b01};   // mostly kept opcodes
         w[11]    = 1'b0;   // r0..r3 only, so hazards are dense
         w[8]     = 1'b0;
         w[2]     = 1'b0;
         if ($urandom % 12 == 0)
            w = '0;
         put_word(w);
      end
   endtask

   initial begin
      gwe = 1'b0;
      forever #(CLK_PERIOD / 2) gwe = ~gwe;
   end

   always @(posedge gwe) cyc <= cyc + 1;

   // instruction memory answers the fetch address a little after the edge
   always @(posedge gwe) begin
      #DRIVE_DLY;
      imem_insn_a = mem_word(imem_addr);
      imem_insn_b = mem_word(imem_addr + 16'd1);
   end

   always @(negedge gwe) begin
      if (cyc >= LIVE_CYC)
         predict_pair();
   end

   startup_idle: assert property (@(posedge gwe) (cyc >= 1 && cyc < LIVE_CYC) |->
         (!wb_we[0] && !wb_we[1] && wb_stall[0] == lc4_pipe_pkg::STALL_EMPTY &&
          wb_stall[1] == lc4_pipe_pkg::STALL_EMPTY))
      else begin
         startup_errs++;
         $display("** Error: startup_idle expected we 0/0 stall 2/2 actual we %b/%b stall %0d/%0d",
                  $sampled(wb_we[0]), $sampled(wb_we[1]), $sampled(wb_stall[0]),
                  $sampled(wb_stall[1]));
      end

   for (genvar l = 0; l < 2; l++) begin : g_lane
      stall_chk: assert property (@(posedge gwe) cyc >= LIVE_CYC |-> wb_stall[l] == exp_stall[l])
         else begin
            trace_errs++;
            $display("** Error: lane%0d_stall expected %0d actual %0d", l, exp_stall[l],
                     $sampled(wb_stall[l]));
         end
      pc_chk: assert property (@(posedge gwe)
            cyc >= LIVE_CYC && exp_stall[l] != lc4_pipe_pkg::STALL_SPLIT |-> wb_pc[l] == exp_pc[l])
         else begin
            trace_errs++;
            $display("** Error: lane%0d_pc expected %h actual %h", l, exp_pc[l], $sampled(wb_pc[l]));
         end
      insn_chk: assert property (@(posedge gwe) cyc >= LIVE_CYC &&
            exp_stall[l] != lc4_pipe_pkg::STALL_SPLIT |-> wb_insn[l] == exp_insn[l])
         else begin
            trace_errs++;
            $display("** Error: lane%0d_insn expected %h actual %h", l, exp_insn[l],
                     $sampled(wb_insn[l]));
         end
      we_chk: assert property (@(posedge gwe) cyc >= LIVE_CYC |-> wb_we[l] == exp_we[l])
         else begin
            data_errs++;
            $display("** Error: lane%0d_we expected %b actual %b", l, exp_we[l], $sampled(wb_we[l]));
         end
      wsel_chk: assert property (@(posedge gwe) cyc >= LIVE_CYC && exp_we[l] |->
            wb_wsel[l] == exp_wsel[l])
         else begin
            data_errs++;
            $display("** Error: lane%0d_wsel expected %0d actual %0d", l, exp_wsel[l],
                     $sampled(wb_wsel[l]));
         end
      data_chk: assert property (@(posedge gwe) cyc >= LIVE_CYC && exp_we[l] |->
            wb_data[l] == exp_data[l])
         else begin
            data_errs++;
            $display("** Error: lane%0d_data expected %h actual %h", l, exp_data[l],
                     $sampled(wb_data[l]));
         end
   end

   initial begin
      wait (loaded);
      #((RST_CYCLES + PIPE_DEPTH + prog_len + WDOG_MARGIN) * CLK_PERIOD);
      $display("watchdog: program did not retire within the expected number of cycles");
      $display("Test FAILED");
      $finish;
   end

   initial begin
      void'($urandom(RAND_SEED));
      rst_n       = 1'b0;
      imem_insn_a = '0;
      imem_insn_b = '0;
      for (int i = 0; i < MEM_WORDS; i++)
         mem[i[7:0]] = '0;
      for (int i = 0; i < 8; i++)
         model_regs[i[2:0]] = '0;   // register file resets to zero
      load_program();
      loaded = 1'b1;
      repeat (RST_CYCLES) @(posedge gwe);
      #DRIVE_DLY rst_n = 1'b1;
      wait (model_pc >= lc4_pipe_pkg::RESET_PC + 16'(prog_len));
      repeat (2) @(posedge gwe);   // let the last predictions be checked
      $display("summary: %0d words, startup errors %0d, trace errors %0d, data errors %0d",
               prog_len, startup_errs, trace_errs, data_errs);
      if (startup_errs + trace_errs + data_errs == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: files.f
hdl/lc4_isa_pkg.sv
hdl/lc4_pipe_pkg.sv
hdl/lane_result_if.sv
hdl/fetch_unit.sv
hdl/issue_unit.sv
hdl/regfile_2w4r.sv
hdl/lc4_alu_lite.sv
hdl/execute_stage.sv
hdl/lc4_superscalar_top.sv
tests/tb_lc4_superscalar.sv

// File: run_sim.sh
#!/bin/sh
# compile with Verilator, run the testbench and scan the log for the fail message
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_lc4_superscalar

verilator --binary --timing --assert -j 0 --top-module "$TOP" -Mdir obj_dir -f files.f
if [ $? -ne 0 ]; then
   echo "verilator compile failed"
   exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
   exit 1
fi
exit 0
